//--- filelist.f
source/cache_pkg.sv
source/cache_ctrl.sv
source/tag_store.sv
source/data_store.sv
source/cache_top.sv
sim/mem_model.sv
sim/cache_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module cache_tb -o cache_sim \
    || { echo "build failed"; exit 1; }

out=$(./obj_dir/cache_sim 2>&1)
echo "$out"
grep -q "Everything OK" <<< "$out" && exit 0 || exit 1

//--- sim/cache_tb.sv
`default_nettype none

module cache_tb;
    import cache_pkg::*;

    localparam int index_bits = 8;
    localparam int num_sets   = 1 << index_bits;
    localparam int num_reqs   = 39;
    localparam int max_cycles = num_reqs * 40 + 20;

    logic clk;
    logic resetn;
    logic valid;
    cpu_req_t req;
    logic addr_ok, data_ok, rd_req, rd_rdy, ret_valid, ret_last, wr_req, wr_rdy;
    logic [word_bits-1:0] rdata, ret_data;
    logic [addr_bits-1:0] rd_addr;
    mem_wr_t wr_line;

    // shadow cache and memory
    logic [line_bits-1:0] sh_line [2][num_sets];
    logic [19:0]          sh_tag [2][num_sets];
    logic                 sh_valid [2][num_sets];
    logic                 sh_dirty [2][num_sets];
    logic                 sh_mru [num_sets];
    logic [line_bits-1:0] sh_mem [logic [addr_bits-1:0]];

    string                test_name;
    op_t                  exp_op;
    logic                 exp_hit;
    logic                 exp_wb;
    logic [word_bits-1:0] exp_rdata;
    logic [addr_bits-1:0] exp_rd_addr;
    logic [159:0]         exp_wr_line;
    logic [1:0]           wb_count;
    logic                 pending;
    logic [15:0]          lfsr;
    int                   cycles;

    cache_top #(.index_bits(index_bits)) dut_i (
        .clk(clk), .resetn(resetn), .valid(valid), .req(req),
        .addr_ok(addr_ok), .data_ok(data_ok), .rdata(rdata),
        .rd_req(rd_req), .rd_addr(rd_addr), .rd_rdy(rd_rdy),
        .ret_valid(ret_valid), .ret_last(ret_last), .ret_data(ret_data),
        .wr_req(wr_req), .wr_line(wr_line), .wr_rdy(wr_rdy)
    );

    mem_model mem_i (
        .clk(clk), .resetn(resetn), .rd_req(rd_req), .rd_addr(rd_addr), .rd_rdy(rd_rdy),
        .ret_valid(ret_valid), .ret_last(ret_last), .ret_data(ret_data),
        .wr_req(wr_req), .wr_line(wr_line), .wr_rdy(wr_rdy)
    );

    task automatic fail_value(input string what, input logic [159:0] exp, input logic [159:0] act);
        $display("[FAIL] %s: %s expected %h actual %h", test_name, what, exp, act);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic fail_msg(input string what);
        $display("%s: %s", test_name, what);
        $display("Something failed");
        $fatal(1);
    endtask

    // write-back count and outstanding request, tracked at each edge
    always @(posedge clk)
    begin
        if (!resetn || addr_ok)
            wb_count <= '0;
        else if (wr_req && wr_rdy)
            wb_count <= wb_count + 1'b1;
        if (!resetn)
            pending <= 1'b0;
        else if (addr_ok)
            pending <= 1'b1;
        else if (data_ok)
            pending <= 1'b0;
    end

    a_read_data: assert property (@(posedge clk) disable iff (!resetn)
        data_ok && exp_op == op_read |-> rdata == exp_rdata)
        else fail_value("read data", 160'(exp_rdata), 160'($sampled(rdata)));
    a_hit_latency: assert property (@(posedge clk) disable iff (!resetn)
        addr_ok && exp_hit |=> data_ok)
        else fail_msg("hit did not answer one cycle after addr_ok");
    a_miss_latency: assert property (@(posedge clk) disable iff (!resetn)
        addr_ok && !exp_hit |=> !data_ok)
        else fail_msg("miss answered at lookup without a refill");
    a_no_refill: assert property (@(posedge clk) disable iff (!resetn)
        rd_req |-> !exp_hit)
        else fail_msg("memory read issued on a hit");
    a_rd_addr: assert property (@(posedge clk) disable iff (!resetn)
        rd_req |-> rd_addr == exp_rd_addr)
        else fail_value("refill address", 160'(exp_rd_addr), 160'($sampled(rd_addr)));
    a_no_wb: assert property (@(posedge clk) disable iff (!resetn)
        wr_req |-> exp_wb)
        else fail_msg("write-back issued for a clean or empty victim");
    a_wb_line: assert property (@(posedge clk) disable iff (!resetn)
        wr_req |-> wr_line == exp_wr_line)
        else fail_value("write-back line", exp_wr_line, $sampled(wr_line));
    a_wb_count: assert property (@(posedge clk) disable iff (!resetn)
        data_ok |-> wb_count == 2'(exp_wb))
        else fail_value("write-back count", 160'(exp_wb), 160'($sampled(wb_count)));
    a_one_addr_ok: assert property (@(posedge clk) disable iff (!resetn)
        addr_ok |-> !pending)
        else fail_msg("addr_ok before data_ok of the previous request");
    a_one_data_ok: assert property (@(posedge clk) disable iff (!resetn)
        data_ok |-> pending)
        else fail_msg("data_ok without an outstanding request");
    a_rd_stable: assert property (@(posedge clk) disable iff (!resetn)
        rd_req && !rd_rdy |=> $stable(rd_addr))
        else fail_msg("rd_addr changed while waiting for rd_rdy");
    a_wr_stable: assert property (@(posedge clk) disable iff (!resetn)
        wr_req && !wr_rdy |=> $stable(wr_line))
        else fail_msg("wr_line changed while waiting for wr_rdy");

    // x^16 + x^14 + x^13 + x^11 + 1
    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [line_bits-1:0] mem_line(input logic [addr_bits-1:0] a);
        logic [line_bits-1:0] l;
        if (sh_mem.exists(a))
            return sh_mem[a];
        for (int i = 0; i < 4; i++)
            l[32*i +: 32] = (a + 32'(4 * i)) ^ 32'h5a5a_5a5a;
        return l;
    endfunction

    // expected outcome of one request, shadow state moved past it
    task automatic predict(input op_t op, input logic [31:0] addr,
                           input logic [3:0] wstrb, input logic [31:0] wdata);
        logic [7:0]  idx;
        logic [19:0] tg;
        int          wd;
        int          way;
        idx = addr[11:4];
        tg  = addr[31:12];
        wd  = int'(addr[3:2]);
        way = 0;
        exp_hit = 1'b0;
        exp_wb  = 1'b0;
        exp_op  = op;
        for (int w = 0; w < 2; w++)
        begin
            if (sh_valid[w][idx] && sh_tag[w][idx] == tg)
            begin
                exp_hit = 1'b1;
                way = w;
            end
        end
        if (!exp_hit)
        begin
            if (!sh_valid[0][idx])
                way = 0;
            else if (!sh_valid[1][idx])
                way = 1;
            else
                way = sh_mru[idx] ? 0 : 1;
            if (sh_valid[way][idx] && sh_dirty[way][idx])
            begin
                exp_wb = 1'b1;
                exp_wr_line = {sh_tag[way][idx], idx, 4'h0, sh_line[way][idx]};
                sh_mem[{sh_tag[way][idx], idx, 4'h0}] = sh_line[way][idx];
            end
            exp_rd_addr = {addr[31:4], 4'h0};
            sh_line[way][idx]  = mem_line(exp_rd_addr);
            sh_tag[way][idx]   = tg;
            sh_valid[way][idx] = 1'b1;
            sh_dirty[way][idx] = 1'b0;
        end
        exp_rdata   = sh_line[way][idx][32*wd +: 32];
        sh_mru[idx] = (way == 1);
        if (op == op_write)
        begin
            sh_dirty[way][idx] = 1'b1;
            for (int k = 0; k < 4; k++)
                if (wstrb[k])
                    sh_line[way][idx][32*wd + 8*k +: 8] = wdata[8*k +: 8];
        end
    endtask

    task automatic issue(input op_t op, input logic [31:0] addr,
                         input logic [3:0] wstrb, input logic [31:0] wdata);
        predict(op, addr, wstrb, wdata);
        valid = 1'b1;
        req   = '{op: op, addr: addr, wstrb: wstrb, wdata: wdata};
        do
            @(negedge clk);
        while (!addr_ok);
        @(posedge clk);
        #1;
        valid = 1'b0;
        do
            @(negedge clk);
        while (!data_ok);
        @(posedge clk);
        #1;
    endtask

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial
    begin
        cycles = 0;
        forever
        begin
            @(posedge clk);
            cycles++;
            if (cycles > max_cycles)
            begin
                $display("timeout after %0d cycles in %s", cycles, test_name);
                $display("Something failed");
                $fatal(1);
            end
        end
    end

    initial
    begin
        logic [31:0] r_tag, r_idx, r_wd, r_op, r_strb, r_data;
        resetn = 1'b0;
        valid  = 1'b0;
        req    = '0;
        lfsr   = 16'd28656;
        exp_op = op_read;
        exp_hit = 1'b0;
        exp_wb = 1'b0;
        exp_rdata = '0;
        exp_rd_addr = '0;
        exp_wr_line = '0;
        test_name = "reset";
        for (int s = 0; s < num_sets; s++)
        begin
            sh_valid[0][s] = 1'b0;
            sh_valid[1][s] = 1'b0;
            sh_dirty[0][s] = 1'b0;
            sh_dirty[1][s] = 1'b0;
            sh_mru[s] = 1'b0;
        end
        repeat (5) @(posedge clk);
        #1;
        resetn = 1'b1;

        test_name = "cold_read_miss";
        issue(op_read, 32'h0000_1040, 4'h0, 32'h0);
        test_name = "read_hit";
        issue(op_read, 32'h0000_1048, 4'h0, 32'h0);
        test_name = "write_hit";
        issue(op_write, 32'h0000_1044, 4'b0101, 32'hdead_beef);
        issue(op_write, 32'h0000_1048, 4'b1000, 32'h1234_5678);
        issue(op_read, 32'h0000_1044, 4'h0, 32'h0);
        issue(op_read, 32'h0000_1048, 4'h0, 32'h0);
        test_name = "lru_evict";
        issue(op_read, 32'h0000_2100, 4'h0, 32'h0);
        issue(op_read, 32'h0000_3100, 4'h0, 32'h0);
        issue(op_write, 32'h0000_2104, 4'b1111, 32'hcafe_f00d);
        issue(op_read, 32'h0000_4100, 4'h0, 32'h0);
        issue(op_read, 32'h0000_3100, 4'h0, 32'h0);
        issue(op_read, 32'h0000_2104, 4'h0, 32'h0);
        test_name = "write_miss";
        issue(op_write, 32'h0000_5208, 4'b0110, 32'h0bad_c0de);
        issue(op_read, 32'h0000_5208, 4'h0, 32'h0);
        issue(op_read, 32'h0000_520c, 4'h0, 32'h0);

        // few tags on two sets, so evictions are frequent
        test_name = "random_stall";
        for (int i = 0; i < 24; i++)
        begin
            rand_bits(2, r_tag);
            rand_bits(1, r_idx);
            rand_bits(2, r_wd);
            rand_bits(1, r_op);
            rand_bits(4, r_strb);
            rand_bits(32, r_data);
            issue(r_op[0] ? op_write : op_read,
                  {12'h0, 8'(r_tag + 1), 8'(r_idx + 32'h30), r_wd[1:0], 2'b00},
                  r_strb[3:0], r_data);
        end

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/mem_model.sv
`default_nettype none

module mem_model (
    input  wire                                clk,
    input  wire                                resetn,
    input  wire                                rd_req,
    input  wire  [cache_pkg::addr_bits-1:0]    rd_addr,
    output logic                               rd_rdy,
    output logic                               ret_valid,
    output logic                               ret_last,
    output logic [cache_pkg::word_bits-1:0]    ret_data,
    input  wire                                wr_req,
    input  wire  cache_pkg::mem_wr_t           wr_line,
    output logic                               wr_rdy
);
    import cache_pkg::*;

    // only lines that were written back are stored
    logic [line_bits-1:0] lines [logic [addr_bits-1:0]];
    logic [15:0]          lfsr;
    logic [line_bits-1:0] rd_line;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [line_bits-1:0] line_at(input logic [addr_bits-1:0] a);
        logic [line_bits-1:0] l;
        if (lines.exists(a))
            return lines[a];
        for (int i = 0; i < words_per_line; i++)
            l[i*word_bits +: word_bits] = (a + 32'(4 * i)) ^ 32'h5a5a_5a5a;
        return l;
    endfunction

    // wait 0 to 3 cycles, two fresh lfsr bits
    task automatic stall();
        int d;
        lfsr = lfsr_step(lfsr);
        d = 2 * int'(lfsr[0]);
        lfsr = lfsr_step(lfsr);
        d = d + int'(lfsr[0]);
        repeat (d)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    initial
    begin
        lfsr      = 16'd28656;
        rd_rdy    = 1'b0;
        wr_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        forever
        begin
            @(posedge clk);
            #1;
            if (resetn && wr_req)
            begin
                stall();
                wr_rdy = 1'b1;
                lines[wr_line.addr] = wr_line.data;
                @(posedge clk);
                #1;
                wr_rdy = 1'b0;
            end
            else if (resetn && rd_req)
            begin
                stall();
                rd_rdy  = 1'b1;
                rd_line = line_at(rd_addr);
                @(posedge clk);
                #1;
                rd_rdy = 1'b0;
                for (int i = 0; i < words_per_line; i++)
                begin
                    stall();
                    ret_valid = 1'b1;
                    ret_last  = (i == words_per_line - 1);
                    ret_data  = rd_line[i*word_bits +: word_bits];
                    @(posedge clk);
                    #1;
                    ret_valid = 1'b0;
                    ret_last  = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/cache_top.sv
`default_nettype none

module cache_top #(
    parameter int index_bits = 8
) (
    input  wire                                clk,
    input  wire                                resetn,
    // cpu side
    input  wire                                valid,
    input  wire cache_pkg::cpu_req_t           req,
    output logic                               addr_ok,
    output logic                               data_ok,
    output logic [cache_pkg::word_bits-1:0]    rdata,
    // memory read side
    output logic                               rd_req,
    output logic [cache_pkg::addr_bits-1:0]    rd_addr,
    input  wire                                rd_rdy,
    input  wire                                ret_valid,
    input  wire                                ret_last,
    input  wire  [cache_pkg::word_bits-1:0]    ret_data,
    // memory write side
    output logic                               wr_req,
    output cache_pkg::mem_wr_t                 wr_line,
    input  wire                                wr_rdy
);
    import cache_pkg::*;

    localparam int tag_bits  = addr_bits - index_bits - offset_bits;
    localparam int beat_bits = $clog2(words_per_line);

    lookup_t                look;
    cpu_req_t               buf_req;
    logic [index_bits-1:0]  tag_index;
    logic [tag_bits-1:0]    tag_value;
    logic                   refill_done;
    logic                   touch;
    logic                   touch_dirty;
    logic                   sel_way;
    logic                   store_we;
    logic                   beat_we;
    logic [beat_bits-1:0]   beat_cnt;
    logic [addr_bits-1:0]   wr_addr;
    logic [line_bits-1:0]   victim_line;

    // victim line goes out together with its address
    assign wr_line = '{addr: wr_addr, data: victim_line};

    cache_ctrl #(
        .index_bits (index_bits)
    ) ctrl_i (
        .clk         (clk),
        .resetn      (resetn),
        .valid       (valid),
        .req         (req),
        .addr_ok     (addr_ok),
        .data_ok     (data_ok),
        .rd_req      (rd_req),
        .rd_addr     (rd_addr),
        .rd_rdy      (rd_rdy),
        .ret_valid   (ret_valid),
        .ret_last    (ret_last),
        .wr_req      (wr_req),
        .wr_addr     (wr_addr),
        .wr_rdy      (wr_rdy),
        .look        (look),
        .tag_index   (tag_index),
        .tag_value   (tag_value),
        .refill_done (refill_done),
        .touch       (touch),
        .touch_dirty (touch_dirty),
        .buf_req     (buf_req),
        .sel_way     (sel_way),
        .store_we    (store_we),
        .beat_we     (beat_we),
        .beat_cnt    (beat_cnt)
    );

    tag_store #(
        .index_bits (index_bits)
    ) tag_i (
        .clk         (clk),
        .resetn      (resetn),
        .tag_index   (tag_index),
        .tag_value   (tag_value),
        .refill_done (refill_done),
        .sel_way     (sel_way),
        .touch       (touch),
        .touch_dirty (touch_dirty),
        .look        (look)
    );

    data_store #(
        .index_bits (index_bits)
    ) data_i (
        .clk         (clk),
        .buf_req     (buf_req),
        .sel_way     (sel_way),
        .store_we    (store_we),
        .beat_we     (beat_we),
        .beat_cnt    (beat_cnt),
        .ret_data    (ret_data),
        .ret_last    (ret_last),
        .hit_way     (look.hit_way),
        .rdata       (rdata),
        .victim_line (victim_line)
    );

endmodule

`default_nettype wire

//--- source/data_store.sv
`default_nettype none

module data_store #(
    parameter int index_bits = 8
) (
    input  wire                                clk,
    input  wire cache_pkg::cpu_req_t           buf_req,
    input  wire                                sel_way,
    input  wire                                store_we,
    input  wire                                beat_we,
    input  wire  [$clog2(cache_pkg::words_per_line)-1:0] beat_cnt,
    input  wire  [cache_pkg::word_bits-1:0]    ret_data,
    input  wire                                ret_last,
    input  wire                                hit_way,
    output logic [cache_pkg::word_bits-1:0]    rdata,
    output logic [cache_pkg::line_bits-1:0]    victim_line
);
    import cache_pkg::*;

    localparam int num_sets       = 1 << index_bits;
    localparam int bytes_per_word = word_bits / 8;
    localparam int beat_bits      = $clog2(words_per_line);

    // two ways of four word banks each
    logic [word_bits-1:0]  bank [2][words_per_line][num_sets];

    logic [index_bits-1:0] index;
    logic [beat_bits-1:0]  word_sel;
    logic [word_bits-1:0]  wr_word;
    logic [word_bits-1:0]  crit_q;
    logic [1:0][words_per_line-1:0][bytes_per_word-1:0] byte_we;

    assign index    = buf_req.addr[offset_bits +: index_bits];
    assign word_sel = buf_req.addr[2 +: beat_bits];
    assign wr_word  = beat_we ? ret_data : buf_req.wdata;

    // refill beat fills a whole word, a store only its strobed bytes
    always_comb
    begin
        byte_we = '0;
        for (int w = 0; w < 2; w++)
        begin
            for (int b = 0; b < words_per_line; b++)
            begin
                if (sel_way == w)
                begin
                    if (beat_we && beat_cnt == b)
                        byte_we[w][b] = '1;
                    else if (store_we && word_sel == b)
                        byte_we[w][b] = buf_req.wstrb;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        for (int w = 0; w < 2; w++)
        begin
            for (int b = 0; b < words_per_line; b++)
            begin
                for (int k = 0; k < bytes_per_word; k++)
                begin
                    if (byte_we[w][b][k])
                        bank[w][b][index][8*k +: 8] <= wr_word[8*k +: 8];
                end
            end
        end
    end

    // requested word may arrive before the last beat
    always_ff @(posedge clk)
    begin
        if (beat_we && beat_cnt == word_sel)
            crit_q <= ret_data;
    end

    always_comb
    begin
        if (beat_we && ret_last)
            rdata = (beat_cnt == word_sel) ? ret_data : crit_q;
        else
            rdata = bank[hit_way][word_sel][index];
    end

    // whole line of the selected way, word 0 in the low bits
    always_comb
    begin
        for (int b = 0; b < words_per_line; b++)
            victim_line[b*word_bits +: word_bits] = bank[sel_way][b][index];
    end

endmodule

`default_nettype wire

//--- source/tag_store.sv
`default_nettype none

module tag_store #(
    parameter int index_bits = 8
) (
    input  wire                                clk,
    input  wire                                resetn,
    input  wire  [index_bits-1:0]              tag_index,
    input  wire  [cache_pkg::addr_bits-index_bits-cache_pkg::offset_bits-1:0] tag_value,
    input  wire                                refill_done,
    input  wire                                sel_way,
    input  wire                                touch,
    input  wire                                touch_dirty,
    output cache_pkg::lookup_t                 look
);
    import cache_pkg::*;

    localparam int tag_bits = addr_bits - index_bits - offset_bits;
    localparam int num_sets = 1 << index_bits;

    logic [tag_bits-1:0]       tag_ram [2][num_sets];
    logic [1:0][num_sets-1:0]  valid_q;
    logic [1:0][num_sets-1:0]  dirty_q;
    // per set, the most recently used way
    logic [num_sets-1:0]       mru_q;

    logic [tag_bits-1:0]       rd_tag [2];
    logic [1:0]                rd_valid;
    logic [1:0]                rd_dirty;
    logic                      rd_mru;
    logic [tag_bits-1:0]       cmp_tag;
    logic [1:0]                way_hit;
    logic                      victim;

    // synchronous read, result seen one cycle later
    always_ff @(posedge clk)
    begin
        rd_tag[0] <= tag_ram[0][tag_index];
        rd_tag[1] <= tag_ram[1][tag_index];
        rd_valid  <= {valid_q[1][tag_index], valid_q[0][tag_index]};
        rd_dirty  <= {dirty_q[1][tag_index], dirty_q[0][tag_index]};
        rd_mru    <= mru_q[tag_index];
        cmp_tag   <= tag_value;
        if (refill_done)
            tag_ram[sel_way][tag_index] <= tag_value;
    end

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            valid_q <= '0;
            dirty_q <= '0;
            mru_q   <= '0;
        end
        else if (refill_done)
        begin
            valid_q[sel_way][tag_index] <= 1'b1;
            dirty_q[sel_way][tag_index] <= 1'b0;
            mru_q[tag_index]            <= sel_way;
        end
        else if (touch)
        begin
            mru_q[tag_index] <= sel_way;
            if (touch_dirty)
                dirty_q[sel_way][tag_index] <= 1'b1;
        end
    end

    always_comb
    begin
        way_hit[0] = rd_valid[0] && (rd_tag[0] == cmp_tag);
        way_hit[1] = rd_valid[1] && (rd_tag[1] == cmp_tag);

        // fill empty ways first, then evict the older way
        if (!rd_valid[0])
            victim = 1'b0;
        else if (!rd_valid[1])
            victim = 1'b1;
        else
            victim = ~rd_mru;

        look.hit          = |way_hit;
        look.hit_way      = way_hit[1];
        look.victim_way   = victim;
        look.victim_dirty = rd_valid[victim] && rd_dirty[victim];
        look.victim_tag   = {rd_tag[victim], {(index_bits + offset_bits){1'b0}}};
    end

    // a line is only refilled after a miss, so no set holds a tag twice
    a_single_hit: assert property (@(posedge clk) disable iff (!resetn)
        !(way_hit[0] && way_hit[1]));

endmodule

`default_nettype wire

//--- source/cache_ctrl.sv
`default_nettype none

module cache_ctrl #(
    parameter int index_bits = 8
) (
    input  wire                                clk,
    input  wire                                resetn,
    input  wire                                valid,
    input  wire cache_pkg::cpu_req_t           req,
    output logic                               addr_ok,
    output logic                               data_ok,
    output logic                               rd_req,
    output logic [cache_pkg::addr_bits-1:0]    rd_addr,
    input  wire                                rd_rdy,
    input  wire                                ret_valid,
    input  wire                                ret_last,
    output logic                               wr_req,
    output logic [cache_pkg::addr_bits-1:0]    wr_addr,
    input  wire                                wr_rdy,
    input  wire cache_pkg::lookup_t            look,
    output logic [index_bits-1:0]              tag_index,
    output logic [cache_pkg::addr_bits-index_bits-cache_pkg::offset_bits-1:0] tag_value,
    output logic                               refill_done,
    output logic                               touch,
    output logic                               touch_dirty,
    output cache_pkg::cpu_req_t                buf_req,
    output logic                               sel_way,
    output logic                               store_we,
    output logic                               beat_we,
    output logic [$clog2(cache_pkg::words_per_line)-1:0] beat_cnt
);
    import cache_pkg::*;

    localparam int tag_bits = addr_bits - index_bits - offset_bits;

    cache_state_t           state;
    cache_state_t           state_next;
    logic                   way_q;
    logic                   last_beat;
    logic [index_bits-1:0]  buf_index;

    assign buf_index = buf_req.addr[offset_bits +: index_bits];
    assign last_beat = ret_valid && ret_last;

    always_ff @(posedge clk)
    begin
        if (!resetn)
            state <= s_idle;
        else
            state <= state_next;
    end

    always_comb
    begin
        state_next = state;
        case (state)
            s_idle:
                if (valid)
                    state_next = s_lookup;
            s_lookup:
                if (look.hit)
                    state_next = (buf_req.op == op_write) ? s_write : s_idle;
                else if (look.victim_dirty)
                    state_next = s_writeback;
                else
                    state_next = s_replace;
            s_writeback:
                if (wr_rdy)
                    state_next = s_replace;
            s_replace:
                if (rd_rdy)
                    state_next = s_refill;
            s_refill:
                if (last_beat)
                    state_next = (buf_req.op == op_write) ? s_write : s_idle;
            default:
                state_next = s_idle;
        endcase
    end

    // request buffer, loaded on the addr_ok edge
    always_ff @(posedge clk)
    begin
        if (addr_ok)
            buf_req <= req;
    end

    // way chosen at lookup, kept for store, writeback and refill
    always_ff @(posedge clk)
    begin
        if (!resetn)
            way_q <= 1'b0;
        else if (state == s_lookup)
            way_q <= look.hit ? look.hit_way : look.victim_way;
    end

    always_ff @(posedge clk)
    begin
        if (!resetn)
            beat_cnt <= '0;
        else if (beat_we)
            beat_cnt <= ret_last ? '0 : beat_cnt + 1'b1;
    end

    // tag store is read with the incoming address while idle
    assign tag_index = (state == s_idle) ? req.addr[offset_bits +: index_bits] : buf_index;
    assign tag_value = (state == s_idle) ? req.addr[addr_bits-1 -: tag_bits]
                                         : buf_req.addr[addr_bits-1 -: tag_bits];

    assign sel_way = (state == s_lookup) ? (look.hit ? look.hit_way : look.victim_way) : way_q;

    assign addr_ok     = (state == s_idle) && valid;
    assign data_ok     = ((state == s_lookup) && look.hit) || ((state == s_refill) && last_beat);
    assign refill_done = (state == s_refill) && last_beat;
    assign touch       = ((state == s_lookup) && look.hit) || (state == s_write);
    assign touch_dirty = (buf_req.op == op_write);
    assign store_we    = (state == s_write);
    assign beat_we     = (state == s_refill) && ret_valid;

    // memory side, both addresses line aligned
    assign rd_req  = (state == s_replace);
    assign wr_req  = (state == s_writeback);
    assign rd_addr = {buf_req.addr[addr_bits-1:offset_bits], {offset_bits{1'b0}}};
    assign wr_addr = {look.victim_tag[addr_bits-1 -: tag_bits], buf_index, {offset_bits{1'b0}}};

    a_req_excl: assert property (@(posedge clk) disable iff (!resetn)
        !(rd_req && wr_req));

    a_data_ok_state: assert property (@(posedge clk) disable iff (!resetn)
        data_ok |-> (state == s_lookup || state == s_refill));

endmodule

`default_nettype wire

//--- source/cache_pkg.sv
`default_nettype none

package cache_pkg;

    // address and data geometry
    localparam int addr_bits      = 32;
    localparam int word_bits      = 32;
    localparam int offset_bits    = 4;
    localparam int words_per_line = 4;
    localparam int line_bits      = 128;

    typedef enum logic
    {
        op_read  = 1'b0,
        op_write = 1'b1
    } op_t;

    // controller states
    typedef enum logic [2:0]
    {
        s_idle      = 3'd0,
        s_lookup    = 3'd1,
        s_write     = 3'd2,
        s_writeback = 3'd3,
        s_replace   = 3'd4,
        s_refill    = 3'd5
    } cache_state_t;

    // cpu request as held by the cpu until addr_ok
    typedef struct packed
    {
        op_t                      op;
        logic [addr_bits-1:0]     addr;
        logic [word_bits/8-1:0]   wstrb;
        logic [word_bits-1:0]     wdata;
    } cpu_req_t;

    // one full-line write-back transfer
    typedef struct packed
    {
        logic [addr_bits-1:0]     addr;
        logic [line_bits-1:0]     data;
    } mem_wr_t;

    // tag store result, victim_tag is left-aligned
    typedef struct packed
    {
        logic                     hit;
        logic                     hit_way;
        logic                     victim_way;
        logic                     victim_dirty;
        logic [addr_bits-1:0]     victim_tag;
    } lookup_t;

endpackage

`default_nettype wire
